// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int wordWidth = 32;
    localparam int regCount  = 32;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [4:0]           regAddrT;
    typedef logic [4:0]           shamtT;
    typedef logic [5:0]           functT;
    typedef logic [5:0]           opcodeT;
    typedef logic [15:0]          immT;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // R-type function field
    localparam functT functSll  = 6'h00;
    localparam functT functSrl  = 6'h02;
    localparam functT functSra  = 6'h03;
    localparam functT functSllv = 6'h04;
    localparam functT functSrlv = 6'h06;
    localparam functT functJr   = 6'h08;
    localparam functT functJalr = 6'h09;
    localparam functT functAdd  = 6'h20;
    localparam functT functSub  = 6'h22;
    localparam functT functAnd  = 6'h24;
    localparam functT functOr   = 6'h25;
    localparam functT functXor  = 6'h26;
    localparam functT functNor  = 6'h27;
    localparam functT functSlt  = 6'h2a;

    // Immediate-form opcodes
    localparam opcodeT opBeq  = 6'h04;
    localparam opcodeT opBne  = 6'h05;
    localparam opcodeT opAddi = 6'h08;
    localparam opcodeT opSlti = 6'h0a;
    localparam opcodeT opAndi = 6'h0c;
    localparam opcodeT opOri  = 6'h0d;
    localparam opcodeT opXori = 6'h0e;
    localparam opcodeT opLui  = 6'h0f;

    typedef enum logic [1:0] {
        rType,
        immArith,
        branch,
        jumpReg
    } instrClassT;

    // Variable shifts reuse the plain shift ops, only operand A differs
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpT;

endpackage

`default_nettype wire

// File: logic/pipePkg.sv
`default_nettype none

package pipePkg;

    // Operand source chosen by the forwarding unit
    typedef logic [1:0] fwdSelT;

    localparam fwdSelT fwdRegFile = 2'd0;
    localparam fwdSelT fwdMemWb   = 2'd1;
    localparam fwdSelT fwdExMem   = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    // functOrOpcode holds funct for rType and jumpReg, opcode otherwise
    typedef struct packed {
        logic               valid;
        isaPkg::instrClassT instrClass;
        isaPkg::functT      functOrOpcode;
        isaPkg::regAddrT    rs;
        isaPkg::regAddrT    rt;
        isaPkg::regAddrT    rd;
        isaPkg::shamtT      shamt;
        isaPkg::immT        imm;
        isaPkg::wordT       pc;
    } issueT;

    // valid here means the slot writes a register
    typedef struct packed {
        logic            valid;
        isaPkg::regAddrT destReg;
        isaPkg::wordT    result;
    } exMemT;

    typedef struct packed {
        logic            valid;
        isaPkg::regAddrT destReg;
        isaPkg::wordT    result;
    } memWbT;

endpackage

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire isaPkg::regAddrT raddrA,
    input  wire isaPkg::regAddrT raddrB,
    output isaPkg::wordT         rdataA,
    output isaPkg::wordT         rdataB,
    input  wire logic            we,
    input  wire isaPkg::regAddrT waddr,
    input  wire isaPkg::wordT    wdata
);

    isaPkg::wordT regs [isaPkg::regCount];

    // Write on the rising edge, whole array cleared by reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < isaPkg::regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

    // Register 0 always reads zero
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

// File: logic/forwardingUnit.sv
`timescale 1ns/100ps
`default_nettype none

module forwardingUnit
(
    input  wire isaPkg::regAddrT rs,
    input  wire isaPkg::regAddrT rt,
    input  wire pipePkg::exMemT  exMem,
    input  wire pipePkg::memWbT  memWb,
    output pipePkg::fwdSelT      selA,
    output pipePkg::fwdSelT      selB
);

    // Youngest matching writer wins
    function automatic pipePkg::fwdSelT pickSource(input isaPkg::regAddrT src,
                                                   input pipePkg::exMemT  exSlot,
                                                   input pipePkg::memWbT  wbSlot);
        pipePkg::fwdSelT sel;
        sel = pipePkg::fwdRegFile;
        if (src != '0)
        begin
            if (exSlot.valid && (exSlot.destReg == src))
                sel = pipePkg::fwdExMem;
            else if (wbSlot.valid && (wbSlot.destReg == src))
                sel = pipePkg::fwdMemWb;
        end
        return sel;
    endfunction

    assign selA = pickSource(rs, exMem, memWb);
    assign selB = pickSource(rt, exMem, memWb);

endmodule

`default_nettype wire

// File: logic/aluControl.sv
`timescale 1ns/100ps
`default_nettype none

module aluControl
(
    input  wire isaPkg::instrClassT instrClass,
    input  wire isaPkg::functT      functOrOpcode,
    output isaPkg::aluOpT           aluOp,
    output logic                    useImm,
    output logic                    useShamt,
    output logic                    linkPc
);

    always_comb
    begin
        aluOp    = isaPkg::aluAdd;
        useImm   = 1'b0;
        useShamt = 1'b0;
        linkPc   = 1'b0;
        unique case (instrClass)
            isaPkg::rType:
            begin
                case (functOrOpcode)
                    isaPkg::functSub:  aluOp = isaPkg::aluSub;
                    isaPkg::functAnd:  aluOp = isaPkg::aluAnd;
                    isaPkg::functOr:   aluOp = isaPkg::aluOr;
                    isaPkg::functXor:  aluOp = isaPkg::aluXor;
                    isaPkg::functNor:  aluOp = isaPkg::aluNor;
                    isaPkg::functSlt:  aluOp = isaPkg::aluSlt;
                    isaPkg::functSllv: aluOp = isaPkg::aluSll;
                    isaPkg::functSrlv: aluOp = isaPkg::aluSrl;
                    isaPkg::functSll:
                    begin
                        aluOp    = isaPkg::aluSll;
                        useShamt = 1'b1;
                    end
                    isaPkg::functSrl:
                    begin
                        aluOp    = isaPkg::aluSrl;
                        useShamt = 1'b1;
                    end
                    isaPkg::functSra:
                    begin
                        aluOp    = isaPkg::aluSra;
                        useShamt = 1'b1;
                    end
                    default:           aluOp = isaPkg::aluAdd;
                endcase
            end
            isaPkg::immArith:
            begin
                useImm = 1'b1;
                case (functOrOpcode)
                    isaPkg::opAndi: aluOp = isaPkg::aluAnd;
                    isaPkg::opOri:  aluOp = isaPkg::aluOr;
                    isaPkg::opXori: aluOp = isaPkg::aluXor;
                    isaPkg::opSlti: aluOp = isaPkg::aluSlt;
                    isaPkg::opLui:  aluOp = isaPkg::aluLui;
                    default:        aluOp = isaPkg::aluAdd;
                endcase
            end
            // Equality test comes from the zero flag of a subtract
            isaPkg::branch:  aluOp = isaPkg::aluSub;
            // jalr computes its link as pc plus one
            isaPkg::jumpReg: linkPc = (functOrOpcode == isaPkg::functJalr);
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
(
    input  wire isaPkg::wordT  a,
    input  wire isaPkg::wordT  b,
    input  wire isaPkg::aluOpT op,
    output isaPkg::wordT       result,
    output logic               zero
);

    // Shift amount always comes from operand A
    isaPkg::shamtT shiftAmt;

    assign shiftAmt = a[4:0];

    always_comb
    begin
        unique case (op)
            isaPkg::aluAdd: result = a + b;
            isaPkg::aluSub: result = a - b;
            isaPkg::aluAnd: result = a & b;
            isaPkg::aluOr:  result = a | b;
            isaPkg::aluXor: result = a ^ b;
            isaPkg::aluNor: result = ~(a | b);
            isaPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            isaPkg::aluSll: result = b << shiftAmt;
            isaPkg::aluSrl: result = b >> shiftAmt;
            isaPkg::aluSra: result = $signed(b) >>> shiftAmt;
            isaPkg::aluLui: result = {b[15:0], 16'b0};
            default:        result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            hold,
    input  wire pipePkg::issueT  issue,
    input  wire isaPkg::wordT    rdataA,
    input  wire isaPkg::wordT    rdataB,
    input  wire pipePkg::fwdSelT selA,
    input  wire pipePkg::fwdSelT selB,
    input  wire isaPkg::wordT    exMemFwd,
    input  wire isaPkg::wordT    memWbFwd,
    output pipePkg::exMemT       exMem,
    output logic                 redirect,
    output isaPkg::wordT         redirectTarget
);

    isaPkg::aluOpT   aluOp;
    logic            useImm;
    logic            useShamt;
    logic            linkPc;
    logic            zeroExt;
    logic            aluZero;
    logic            taken;
    logic            writesReg;
    isaPkg::wordT    fwdA;
    isaPkg::wordT    fwdB;
    isaPkg::wordT    extImm;
    isaPkg::wordT    opA;
    isaPkg::wordT    opB;
    isaPkg::wordT    aluResult;
    isaPkg::regAddrT destReg;

    aluControl aluCtrl
    (
        .instrClass    (issue.instrClass),
        .functOrOpcode (issue.functOrOpcode),
        .aluOp         (aluOp),
        .useImm        (useImm),
        .useShamt      (useShamt),
        .linkPc        (linkPc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operands
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (selA)
            pipePkg::fwdExMem: fwdA = exMemFwd;
            pipePkg::fwdMemWb: fwdA = memWbFwd;
            default:           fwdA = rdataA;
        endcase
        case (selB)
            pipePkg::fwdExMem: fwdB = exMemFwd;
            pipePkg::fwdMemWb: fwdB = memWbFwd;
            default:           fwdB = rdataB;
        endcase
    end

    // Logical immediates zero-extend, everything else sign-extends
    assign zeroExt = (issue.instrClass == isaPkg::immArith) &&
                     ((issue.functOrOpcode == isaPkg::opAndi) ||
                      (issue.functOrOpcode == isaPkg::opOri)  ||
                      (issue.functOrOpcode == isaPkg::opXori));
    assign extImm  = zeroExt ? {16'b0, issue.imm} : {{16{issue.imm[15]}}, issue.imm};

    assign opA = linkPc   ? issue.pc :
                 useShamt ? isaPkg::wordT'(issue.shamt) : fwdA;
    assign opB = linkPc   ? isaPkg::wordT'(1) :
                 useImm   ? extImm : fwdB;

    alu aluInst
    (
        .a      (opA),
        .b      (opB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        taken          = 1'b0;
        redirectTarget = issue.pc + 32'd1 + extImm;
        case (issue.instrClass)
            isaPkg::branch:
            begin
                if (issue.functOrOpcode == isaPkg::opBeq)
                    taken = aluZero;
                else if (issue.functOrOpcode == isaPkg::opBne)
                    taken = !aluZero;
            end
            isaPkg::jumpReg:
            begin
                taken          = 1'b1;
                redirectTarget = fwdA;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect = issue.valid && taken;

    // Destination is rt for immediates, rd for R-type and jalr
    assign destReg   = (issue.instrClass == isaPkg::immArith) ? issue.rt : issue.rd;
    assign writesReg = (issue.instrClass == isaPkg::rType)    ||
                       (issue.instrClass == isaPkg::immArith) || linkPc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exMem.valid <= 1'b0;
        end
        else if (!hold)
        begin
            exMem.valid   <= issue.valid && writesReg && (destReg != '0);
            exMem.destReg <= destReg;
            exMem.result  <= aluResult;
        end
    end

endmodule

`default_nettype wire

// File: logic/retireStages.sv
`timescale 1ns/100ps
`default_nettype none

module retireStages
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           hold,
    input  wire pipePkg::exMemT exMem,
    output pipePkg::memWbT      memWb,
    output logic                we,
    output isaPkg::regAddrT     waddr,
    output isaPkg::wordT        wdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Memory stage
    ////////////////////////////////////////////////////////////////////////////

    // No data port yet, the slot passes straight into memWb
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            memWb.valid <= 1'b0;
        end
        else if (!hold)
        begin
            memWb.valid   <= exMem.valid;
            memWb.destReg <= exMem.destReg;
            memWb.result  <= exMem.result;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback request
    ////////////////////////////////////////////////////////////////////////////

    assign we    = memWb.valid && !hold;
    assign waddr = memWb.destReg;
    assign wdata = memWb.result;

endmodule

`default_nettype wire

// File: logic/executeCore.sv
`timescale 1ns/100ps
`default_nettype none

module executeCore
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           hold,
    input  wire pipePkg::issueT issue,
    output logic                redirect,
    output isaPkg::wordT        redirectTarget,
    output logic                wbValid,
    output isaPkg::regAddrT     wbReg,
    output isaPkg::wordT        wbData
);

    isaPkg::wordT    rdataA;
    isaPkg::wordT    rdataB;
    pipePkg::fwdSelT selA;
    pipePkg::fwdSelT selB;
    pipePkg::exMemT  exMem;
    pipePkg::memWbT  memWb;
    logic            we;
    isaPkg::regAddrT waddr;
    isaPkg::wordT    wdata;

    regFile regs
    (
        .clk    (clk),
        .rst    (rst),
        .raddrA (issue.rs),
        .raddrB (issue.rt),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    forwardingUnit fwd
    (
        .rs    (issue.rs),
        .rt    (issue.rt),
        .exMem (exMem),
        .memWb (memWb),
        .selA  (selA),
        .selB  (selB)
    );

    executeStage exStage
    (
        .clk            (clk),
        .rst            (rst),
        .hold           (hold),
        .issue          (issue),
        .rdataA         (rdataA),
        .rdataB         (rdataB),
        .selA           (selA),
        .selB           (selB),
        .exMemFwd       (exMem.result),
        .memWbFwd       (memWb.result),
        .exMem          (exMem),
        .redirect       (redirect),
        .redirectTarget (redirectTarget)
    );

    retireStages retire
    (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .exMem (exMem),
        .memWb (memWb),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata)
    );

    // Writeback port mirrors the memWb register
    assign wbValid = memWb.valid;
    assign wbReg   = memWb.destReg;
    assign wbData  = memWb.result;

endmodule

`default_nettype wire

// File: verification/executeCore_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module executeCoreAssertions
(
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            hold,
    input wire pipePkg::issueT  issue,
    input wire logic            redirect,
    input wire logic            wbValid,
    input wire isaPkg::regAddrT wbReg,
    input wire isaPkg::wordT    wbData
);

    // Reset empties memWb
    resetClearsWb: assert property (@(posedge clk) rst |=> !wbValid)
        else $error("wbValid high in the cycle after reset");

    redirectNeedsIssue: assert property (@(posedge clk) redirect |-> issue.valid)
        else $error("redirect raised without a valid issue");

    // Writes to register 0 never reach writeback
    wbRegNonzero: assert property (@(posedge clk) disable iff (rst) wbValid |-> (wbReg != '0))
        else $error("writeback to register 0");

    holdKeepsWb: assert property (@(posedge clk) disable iff (rst)
        hold |=> ($stable(wbValid) && $stable(wbReg) && $stable(wbData)))
        else $error("writeback port changed across a held cycle");

endmodule

`default_nettype wire

// File: verification/executeCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module executeCoreTb;

    localparam int resetCycles    = 2;
    localparam int burstLen       = 8;
    localparam int arithCount     = 60;
    localparam int chainCount     = 60;
    localparam int setupCount     = 8;
    localparam int branchCount    = 40;
    localparam int holdChainCount = 40;
    localparam int holdBudget     = 40;
    localparam int drainCycles    = 2;
    // Each branch may be preceded by one chained instruction
    localparam int cycleLimit = resetCycles + burstLen + arithCount + chainCount + setupCount
                              + 2 * branchCount + holdChainCount + holdBudget
                              + 5 * drainCycles + 20;

    // Expected content of the writeback port
    typedef struct packed {
        logic            valid;
        isaPkg::regAddrT destReg;
        isaPkg::wordT    result;
    } wbEntryT;

    logic            clk;
    logic            rst;
    logic            hold;
    pipePkg::issueT  issue;
    logic            redirect;
    isaPkg::wordT    redirectTarget;
    logic            wbValid;
    isaPkg::regAddrT wbReg;
    isaPkg::wordT    wbData;

    integer          seed;
    int              errorCount;
    int              checkCount;
    int              cycleCount;
    int              holdsLeft;
    isaPkg::wordT    nextPc;
    isaPkg::wordT    modelRegs [32];
    isaPkg::regAddrT recentDest [3];
    wbEntryT         pending [$];
    wbEntryT         expWb;

    isaPkg::functT rFuncts [12] = '{isaPkg::functAdd, isaPkg::functSub, isaPkg::functAnd,
                                    isaPkg::functOr, isaPkg::functXor, isaPkg::functNor,
                                    isaPkg::functSlt, isaPkg::functSll, isaPkg::functSrl,
                                    isaPkg::functSra, isaPkg::functSllv, isaPkg::functSrlv};
    isaPkg::opcodeT iOps [6] = '{isaPkg::opAddi, isaPkg::opAndi, isaPkg::opOri,
                                 isaPkg::opXori, isaPkg::opSlti, isaPkg::opLui};

    executeCore UUT
    (
        .clk            (clk),
        .rst            (rst),
        .hold           (hold),
        .issue          (issue),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .wbValid        (wbValid),
        .wbReg          (wbReg),
        .wbData         (wbData)
    );

    bind executeCore executeCoreAssertions checks
    (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .issue    (issue),
        .redirect (redirect),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    always
    begin
        clk = 1'b0;
        #50;
        clk = 1'b1;
        #50;
    end

    // Run limit
    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic isaPkg::wordT nextRandom();
        return $random(seed);
    endfunction

    function automatic int pick(input int n);
        isaPkg::wordT r;
        r = nextRandom();
        return int'(r % n);
    endfunction

    function automatic isaPkg::regAddrT randomReg(input int lo);
        return isaPkg::regAddrT'(lo + pick(32 - lo));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Reads the model registers as if every older result were already written
    function automatic void evaluate(input pipePkg::issueT ins, output wbEntryT wb,
                                     output logic taken, output isaPkg::wordT target);
        isaPkg::wordT rsVal;
        isaPkg::wordT rtVal;
        isaPkg::wordT sImm;
        isaPkg::wordT zImm;
        rsVal      = modelRegs[ins.rs];
        rtVal      = modelRegs[ins.rt];
        sImm       = {{16{ins.imm[15]}}, ins.imm};
        zImm       = {16'h0000, ins.imm};
        wb.valid   = 1'b0;
        wb.destReg = ins.rd;
        wb.result  = '0;
        taken      = 1'b0;
        target     = ins.pc + 32'd1 + sImm;
        case (ins.instrClass)
            isaPkg::rType:
            begin
                wb.valid = 1'b1;
                case (ins.functOrOpcode)
                    isaPkg::functAdd:  wb.result = rsVal + rtVal;
                    isaPkg::functSub:  wb.result = rsVal - rtVal;
                    isaPkg::functAnd:  wb.result = rsVal & rtVal;
                    isaPkg::functOr:   wb.result = rsVal | rtVal;
                    isaPkg::functXor:  wb.result = rsVal ^ rtVal;
                    isaPkg::functNor:  wb.result = ~(rsVal | rtVal);
                    isaPkg::functSlt:  wb.result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
                    isaPkg::functSll:  wb.result = rtVal << ins.shamt;
                    isaPkg::functSrl:  wb.result = rtVal >> ins.shamt;
                    isaPkg::functSra:  wb.result = $signed(rtVal) >>> ins.shamt;
                    isaPkg::functSllv: wb.result = rtVal << rsVal[4:0];
                    isaPkg::functSrlv: wb.result = rtVal >> rsVal[4:0];
                    default:           wb.valid = 1'b0;
                endcase
            end
            isaPkg::immArith:
            begin
                wb.valid   = 1'b1;
                wb.destReg = ins.rt;
                case (ins.functOrOpcode)
                    isaPkg::opAddi: wb.result = rsVal + sImm;
                    isaPkg::opAndi: wb.result = rsVal & zImm;
                    isaPkg::opOri:  wb.result = rsVal | zImm;
                    isaPkg::opXori: wb.result = rsVal ^ zImm;
                    isaPkg::opSlti: wb.result = ($signed(rsVal) < $signed(sImm)) ? 32'd1 : 32'd0;
                    isaPkg::opLui:  wb.result = {ins.imm, 16'h0000};
                    default:        wb.valid = 1'b0;
                endcase
            end
            isaPkg::branch:
            begin
                if (ins.functOrOpcode == isaPkg::opBeq)
                    taken = (rsVal == rtVal);
                else
                    taken = (rsVal != rtVal);
            end
            default:
            begin
                taken  = 1'b1;
                target = rsVal;
                if (ins.functOrOpcode == isaPkg::functJalr)
                begin
                    wb.valid  = 1'b1;
                    wb.result = ins.pc + 32'd1;
                end
            end
        endcase
        wb.valid = wb.valid && ins.valid && (wb.destReg != '0);
        taken    = taken && ins.valid;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and cycle driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic expectWord(input string name, input isaPkg::wordT got, input isaPkg::wordT exp);
        checkCount++;
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkWriteback();
        expectWord("wbValid", {31'b0, wbValid}, {31'b0, expWb.valid});
        if (expWb.valid)
        begin
            expectWord("wbReg", {27'b0, wbReg}, {27'b0, expWb.destReg});
            expectWord("wbData", wbData, expWb.result);
        end
    endtask

    // Entered and left 10 ns after a rising edge
    task automatic runCycle(input pipePkg::issueT ins, input logic holdIn);
        wbEntryT      entry;
        logic         taken;
        isaPkg::wordT target;
        issue = ins;
        hold  = holdIn;
        evaluate(ins, entry, taken, target);
        @(negedge clk);
        checkWriteback();
        if (!holdIn)
        begin
            expectWord("redirect", {31'b0, redirect}, {31'b0, taken});
            if (taken)
                expectWord("redirectTarget", redirectTarget, target);
            if (entry.valid)
                modelRegs[entry.destReg] = entry.result;
            pending.push_back(entry);
        end
        @(posedge clk);
        #10;
        if (!holdIn)
            expWb = pending.pop_front();
    endtask

    task automatic noteDest(input isaPkg::regAddrT dest);
        recentDest[2] = recentDest[1];
        recentDest[1] = recentDest[0];
        recentDest[0] = dest;
    endtask

    task automatic drainAndReport(input string name, input int errs0, input int checks0);
        repeat (drainCycles)
            runCycle('0, 1'b0);
        $display("%s finished: %0d checks, %0d errors", name, checkCount - checks0,
                 errorCount - errs0);
    endtask

    // Random R-type or immediate instruction writing dest
    task automatic buildArith(input isaPkg::regAddrT rs, input isaPkg::regAddrT rt,
                              input isaPkg::regAddrT dest, output pipePkg::issueT ins);
        isaPkg::wordT r;
        r         = nextRandom();
        ins       = '0;
        ins.valid = 1'b1;
        ins.rs    = rs;
        ins.rt    = rt;
        ins.rd    = dest;
        ins.shamt = r[4:0];
        ins.imm   = r[31:16];
        ins.pc    = nextPc;
        nextPc    = nextPc + 32'd1;
        if (pick(2) == 0)
        begin
            ins.instrClass    = isaPkg::rType;
            ins.functOrOpcode = rFuncts[pick(12)];
        end
        else
        begin
            ins.instrClass    = isaPkg::immArith;
            ins.functOrOpcode = iOps[pick(6)];
            ins.rt            = dest;
        end
        noteDest(dest);
    endtask

    // Sources taken from the last three destinations
    task automatic chainStep(input logic holdAllowed);
        pipePkg::issueT ins;
        buildArith(recentDest[pick(3)], recentDest[pick(3)], randomReg(1), ins);
        while (holdAllowed && (holdsLeft > 0) && (pick(4) == 0))
        begin
            runCycle(ins, 1'b1);
            holdsLeft--;
        end
        runCycle(ins, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testReset();
        pipePkg::issueT ins;
        int             errs0;
        int             checks0;
        errs0   = errorCount;
        checks0 = checkCount;
        @(posedge clk);
        #10;
        @(negedge clk);
        expectWord("wbValid", {31'b0, wbValid}, 32'd0);
        @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (burstLen)
        begin
            ins               = '0;
            ins.valid         = 1'b1;
            ins.instrClass    = isaPkg::rType;
            ins.functOrOpcode = isaPkg::functAdd;
            ins.rd            = randomReg(1);
            ins.pc            = nextPc;
            nextPc            = nextPc + 32'd1;
            runCycle(ins, 1'b0);
        end
        drainAndReport("reset", errs0, checks0);
    endtask

    task automatic testArith();
        pipePkg::issueT  ins;
        isaPkg::regAddrT rs;
        isaPkg::regAddrT rt;
        int              errs0;
        int              checks0;
        errs0   = errorCount;
        checks0 = checkCount;
        repeat (arithCount)
        begin
            // Keep sources clear of anything still in flight
            do
                rs = randomReg(0);
            while ((rs != '0) && ((rs == recentDest[0]) || (rs == recentDest[1])));
            do
                rt = randomReg(0);
            while ((rt != '0) && ((rt == recentDest[0]) || (rt == recentDest[1])));
            buildArith(rs, rt, (pick(8) == 0) ? 5'd0 : randomReg(1), ins);
            runCycle(ins, 1'b0);
        end
        drainAndReport("arith", errs0, checks0);
    endtask

    task automatic testForwarding();
        int errs0;
        int checks0;
        errs0   = errorCount;
        checks0 = checkCount;
        repeat (chainCount)
            chainStep(1'b0);
        drainAndReport("forwarding", errs0, checks0);
    endtask

    task automatic testBranches();
        pipePkg::issueT ins;
        isaPkg::wordT   r;
        int             kind;
        int             errs0;
        int             checks0;
        errs0   = errorCount;
        checks0 = checkCount;
        repeat (setupCount)
            chainStep(1'b0);
        repeat (branchCount)
        begin
            if (pick(2) == 0)
                chainStep(1'b0);
            r         = nextRandom();
            ins       = '0;
            // Occasional bubble and a live rd field on every kind
            ins.valid = (pick(8) != 0);
            ins.imm   = r[15:0];
            ins.pc    = nextRandom();
            ins.rs    = (pick(2) == 0) ? recentDest[pick(3)] : randomReg(0);
            ins.rd    = randomReg(0);
            kind      = pick(4);
            if (kind < 2)
            begin
                ins.instrClass    = isaPkg::branch;
                ins.functOrOpcode = (kind == 0) ? isaPkg::opBeq : isaPkg::opBne;
                ins.rt            = (pick(2) == 0) ? ins.rs : randomReg(0);
                noteDest(5'd0);
            end
            else
            begin
                ins.instrClass    = isaPkg::jumpReg;
                ins.functOrOpcode = (kind == 2) ? isaPkg::functJr : isaPkg::functJalr;
                noteDest((kind == 3) ? ins.rd : 5'd0);
            end
            runCycle(ins, 1'b0);
        end
        drainAndReport("branches", errs0, checks0);
    endtask

    task automatic testHold();
        int errs0;
        int checks0;
        errs0     = errorCount;
        checks0   = checkCount;
        holdsLeft = holdBudget;
        repeat (holdChainCount)
            chainStep(1'b1);
        drainAndReport("hold", errs0, checks0);
    endtask

    initial
    begin
        seed       = 62624;
        errorCount = 0;
        checkCount = 0;
        holdsLeft  = 0;
        nextPc     = 32'h0000_0100;
        rst        = 1'b1;
        hold       = 1'b0;
        issue      = '0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < 3; i++)
            recentDest[i] = '0;
        // exMem is empty after reset
        expWb = '0;
        pending.push_back('0);
        testReset();
        testArith();
        testForwarding();
        testBranches();
        testHold();
        $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/forwardingUnit.sv
logic/aluControl.sv
logic/alu.sv
logic/executeStage.sv
logic/retireStages.sv
logic/executeCore.sv
verification/executeCore_assertions.sv
verification/executeCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= executeCoreTb
FILE_LIST ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed

SOURCES := $(wildcard logic/*.sv verification/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --timing --assert -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
